/* hdl/tex_config.svh */
`ifndef TEX_CONFIG_SVH
`define TEX_CONFIG_SVH

// Q16.16 coordinates
`define TEX_FIX 16

// dimension and coordinate width for sizes up to 64
`define TEX_DIM_W 7
`define TEX_LOD_W 3
`define TEX_LEVELS 7  // 64 down to 1

// texel store
`define TEX_MEM_AW 13
`define TEX_TEXEL_W 32

`endif

/* hdl/tex_pkg.sv */
`default_nettype none
`include "tex_config.svh"

package tex_pkg;

  // code 3 is not named and falls back to clamp
  typedef enum logic [1:0] {
    WRAP_CLAMP  = 2'd0,
    WRAP_REPEAT = 2'd1,
    WRAP_MIRROR = 2'd2
  } wrap_mode_e;

  typedef struct packed {
    logic [`TEX_DIM_W-1:0] base_width;   // power of two
    logic [`TEX_DIM_W-1:0] base_height;  // power of two
  } tex_cfg_t;

  typedef struct packed {
    logic [31:0]           u;  // normalized Q16.16
    logic [31:0]           v;
    logic [`TEX_LOD_W-1:0] lod;
    wrap_mode_e            wrap_u;
    wrap_mode_e            wrap_v;
  } tex_req_t;

  typedef struct packed {
    logic [`TEX_DIM_W-1:0]  tex_x;
    logic [`TEX_DIM_W-1:0]  tex_y;
    logic [`TEX_MEM_AW-1:0] index;  // linear index inside the level
    logic [`TEX_LOD_W-1:0]  lod;
  } tex_coord_t;

  typedef struct packed {
    logic [`TEX_TEXEL_W-1:0] texel;
    logic [`TEX_DIM_W-1:0]   tex_x;
    logic [`TEX_DIM_W-1:0]   tex_y;
    logic [`TEX_LOD_W-1:0]   lod;
  } tex_resp_t;

  // level dimension never below one texel
  function automatic logic [`TEX_DIM_W-1:0] dim_at_lod(
      input logic [`TEX_DIM_W-1:0] base,
      input logic [`TEX_LOD_W-1:0] lod);
    logic [`TEX_DIM_W-1:0] d;
    d = base >> lod;
    return (d == '0) ? `TEX_DIM_W'(1) : d;
  endfunction

endpackage

`default_nettype wire

/* hdl/tex_addr_gen.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tex_config.svh"

module tex_addr_gen (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 req_valid,
  output logic                req_ready,
  input  tex_pkg::tex_req_t   req,
  input  tex_pkg::tex_cfg_t   cfg,
  input  wire                 table_busy,
  output logic                coord_valid,
  input  wire                 coord_ready,
  output tex_pkg::tex_coord_t coord
);

  // integer part of coordinate times level size
  localparam int POS_W = 32 + `TEX_DIM_W - `TEX_FIX;

  typedef struct packed {
    logic [`TEX_DIM_W-1:0] x;
    logic [`TEX_DIM_W-1:0] y;
    logic [`TEX_DIM_W-1:0] width;  // stride for the index
    logic [`TEX_LOD_W-1:0] lod;
  } stage1_t;

  function automatic logic [`TEX_DIM_W-1:0] wrap_axis(
      input logic [POS_W-1:0]      pos,
      input logic [`TEX_DIM_W-1:0] size,
      input tex_pkg::wrap_mode_e   mode);
    logic [`TEX_DIM_W:0]   twice;
    logic [`TEX_DIM_W:0]   mod2;
    logic [`TEX_DIM_W:0]   refl;
    logic [`TEX_DIM_W-1:0] res;
    twice = {size, 1'b0};
    mod2  = pos[`TEX_DIM_W:0] & (twice - 1'b1);  // pos mod 2*size
    refl  = twice - 1'b1 - mod2;
    case (mode)
      tex_pkg::WRAP_REPEAT: res = pos[`TEX_DIM_W-1:0] & (size - 1'b1);
      tex_pkg::WRAP_MIRROR: begin
        // upper half of the period runs backwards
        res = (mod2 >= {1'b0, size}) ? refl[`TEX_DIM_W-1:0] : mod2[`TEX_DIM_W-1:0];
      end
      default: res = (pos >= POS_W'(size)) ? size - 1'b1 : pos[`TEX_DIM_W-1:0];
    endcase
    return res;
  endfunction

  logic [`TEX_DIM_W-1:0] lvl_w;
  logic [`TEX_DIM_W-1:0] lvl_h;
  logic [31+`TEX_DIM_W:0] prod_u;
  logic [31+`TEX_DIM_W:0] prod_v;
  stage1_t s1_next;
  stage1_t s1;
  logic    s1_valid;
  logic    s1_ready;
  logic    s2_ready;

  assign s2_ready  = !coord_valid || coord_ready;
  assign s1_ready  = !s1_valid || s2_ready;
  assign req_ready = s1_ready && !table_busy;  // table rebuild blocks intake

  always_comb begin
    lvl_w  = tex_pkg::dim_at_lod(cfg.base_width, req.lod);
    lvl_h  = tex_pkg::dim_at_lod(cfg.base_height, req.lod);
    prod_u = req.u * lvl_w;
    prod_v = req.v * lvl_h;
    s1_next.x     = wrap_axis(prod_u[31+`TEX_DIM_W:`TEX_FIX], lvl_w, req.wrap_u);
    s1_next.y     = wrap_axis(prod_v[31+`TEX_DIM_W:`TEX_FIX], lvl_h, req.wrap_v);
    s1_next.width = lvl_w;
    s1_next.lod   = req.lod;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      coord_valid <= 1'b0;
    end else begin
      if (s1_ready)
        s1_valid <= req_valid && req_ready;
      if (s2_ready)
        coord_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready)
      s1 <= s1_next;
    if (s1_valid && s2_ready) begin
      coord.tex_x <= s1.x;
      coord.tex_y <= s1.y;
      coord.index <= `TEX_MEM_AW'(s1.y) * `TEX_MEM_AW'(s1.width)
                     + `TEX_MEM_AW'(s1.x);  // row major with level width as stride
      coord.lod   <= s1.lod;
    end
  end

endmodule

`default_nettype wire

/* hdl/mip_offset_calc.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tex_config.svh"

module mip_offset_calc (
  input  wire                          clk,
  input  wire                          rst_n,
  input  tex_pkg::tex_cfg_t            cfg,
  input  wire                          cfg_load,
  output logic                         table_busy,
  input  wire  [`TEX_LOD_W-1:0]        lookup_lod,
  output logic [`TEX_MEM_AW-1:0]       level_offset
);

  tex_pkg::tex_cfg_t      cfg_r;
  logic [`TEX_LOD_W-1:0]  lvl;
  logic [`TEX_MEM_AW-1:0] run_sum;  // start of the current level
  logic [`TEX_MEM_AW-1:0] area;
  logic [`TEX_MEM_AW-1:0] offs [`TEX_LEVELS];

  assign area = `TEX_MEM_AW'(tex_pkg::dim_at_lod(cfg_r.base_width, lvl))
              * `TEX_MEM_AW'(tex_pkg::dim_at_lod(cfg_r.base_height, lvl));

  always_ff @(posedge clk) begin
    if (cfg_load)
      cfg_r <= cfg;
  end

  // one level per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      table_busy <= 1'b0;
      lvl        <= '0;
      run_sum    <= '0;
      for (int i = 0; i < `TEX_LEVELS; i++)
        offs[i] <= '0;
    end else if (cfg_load) begin
      table_busy <= 1'b1;
      lvl        <= '0;
      run_sum    <= '0;
    end else if (table_busy) begin
      offs[lvl] <= run_sum;
      run_sum   <= run_sum + area;
      lvl       <= lvl + 1'b1;
      if (lvl == `TEX_LOD_W'(`TEX_LEVELS - 1))
        table_busy <= 1'b0;  // last level written
    end
  end

  assign level_offset = (lookup_lod < `TEX_LOD_W'(`TEX_LEVELS)) ? offs[lookup_lod] : '0;

endmodule

`default_nettype wire

/* hdl/texel_mem.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tex_config.svh"

module texel_mem (
  input  wire                          clk,
  input  wire                          mem_we,
  input  wire  [`TEX_MEM_AW-1:0]       mem_waddr,
  input  wire  [`TEX_TEXEL_W-1:0]      mem_wdata,
  input  wire                          rd_en,
  input  wire  [`TEX_MEM_AW-1:0]       rd_addr,
  output logic [`TEX_TEXEL_W-1:0]      rd_data
);

  localparam int DEPTH = 2 ** `TEX_MEM_AW;

  logic [`TEX_TEXEL_W-1:0] mem [DEPTH];

  // load port
  always_ff @(posedge clk) begin
    if (mem_we)
      mem[mem_waddr] <= mem_wdata;
  end

  // read data held until the next rd_en
  always_ff @(posedge clk) begin
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* hdl/tex_fetch.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tex_config.svh"

module tex_fetch (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          coord_valid,
  output logic                         coord_ready,
  input  tex_pkg::tex_coord_t          coord,
  output logic [`TEX_LOD_W-1:0]        lookup_lod,
  input  wire  [`TEX_MEM_AW-1:0]       level_offset,
  output logic                         rd_en,
  output logic [`TEX_MEM_AW-1:0]       rd_addr,
  input  wire  [`TEX_TEXEL_W-1:0]      rd_data,
  output logic                         resp_valid,
  input  wire                          resp_ready,
  output tex_pkg::tex_resp_t           resp
);

  typedef struct packed {
    logic [`TEX_DIM_W-1:0] tex_x;
    logic [`TEX_DIM_W-1:0] tex_y;
    logic [`TEX_LOD_W-1:0] lod;
  } fields_t;

  typedef struct packed {
    logic [`TEX_MEM_AW-1:0] addr;
    fields_t                fields;
  } addr_stage_t;

  addr_stage_t a;
  logic        a_valid;
  fields_t     resp_fields;  // travels alongside the ram read
  logic        issue;

  assign lookup_lod  = coord.lod;
  assign issue       = a_valid && (!resp_valid || resp_ready);  // slot free or draining
  assign coord_ready = !a_valid || issue;
  assign rd_en       = issue;
  assign rd_addr     = a.addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_valid    <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      if (coord_ready)
        a_valid <= coord_valid;
      if (issue)
        resp_valid <= 1'b1;
      else if (resp_ready)
        resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (coord_valid && coord_ready) begin
      a.addr         <= level_offset + coord.index;  // chain offset plus index
      a.fields.tex_x <= coord.tex_x;
      a.fields.tex_y <= coord.tex_y;
      a.fields.lod   <= coord.lod;
    end
    if (issue)
      resp_fields <= a.fields;
  end

  always_comb begin
    resp.texel = rd_data;
    resp.tex_x = resp_fields.tex_x;
    resp.tex_y = resp_fields.tex_y;
    resp.lod   = resp_fields.lod;
  end

endmodule

`default_nettype wire

/* hdl/tex_unit_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tex_config.svh"

module tex_unit_top (
  input  wire                          clk,
  input  wire                          rst_n,
  input  tex_pkg::tex_cfg_t            cfg,
  input  wire                          cfg_load,
  input  wire                          mem_we,
  input  wire  [`TEX_MEM_AW-1:0]       mem_waddr,
  input  wire  [`TEX_TEXEL_W-1:0]      mem_wdata,
  input  wire                          req_valid,
  output logic                         req_ready,
  input  tex_pkg::tex_req_t            req,
  output logic                         resp_valid,
  input  wire                          resp_ready,
  output tex_pkg::tex_resp_t           resp
);

  logic                    table_busy;
  logic                    coord_valid;
  logic                    coord_ready;
  tex_pkg::tex_coord_t     coord;
  logic [`TEX_LOD_W-1:0]   lookup_lod;
  logic [`TEX_MEM_AW-1:0]  level_offset;
  logic                    rd_en;
  logic [`TEX_MEM_AW-1:0]  rd_addr;
  logic [`TEX_TEXEL_W-1:0] rd_data;

  tex_addr_gen u_addr_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req         (req),
    .cfg         (cfg),
    .table_busy  (table_busy),
    .coord_valid (coord_valid),
    .coord_ready (coord_ready),
    .coord       (coord)
  );

  mip_offset_calc u_mip_offset (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .cfg_load     (cfg_load),
    .table_busy   (table_busy),
    .lookup_lod   (lookup_lod),
    .level_offset (level_offset)
  );

  texel_mem u_texel_mem (
    .clk       (clk),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  tex_fetch u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .coord_valid  (coord_valid),
    .coord_ready  (coord_ready),
    .coord        (coord),
    .lookup_lod   (lookup_lod),
    .level_offset (level_offset),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready),
    .resp         (resp)
  );

endmodule

`default_nettype wire

/* sim/tex_unit_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module tex_unit_assert (
  input wire                clk,
  input wire                rst_n,
  input wire                req_valid,
  input wire                req_ready,
  input tex_pkg::tex_req_t  req,
  input wire                resp_valid,
  input wire                resp_ready,
  input tex_pkg::tex_resp_t resp,
  input wire                table_busy
);

  // payloads held until the transfer
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else $error("request dropped or changed while stalled");

  resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else $error("response dropped or changed while stalled");

  resp_in_reset: assert property (@(posedge clk) !rst_n |-> !resp_valid)
    else $error("response valid during reset");

  // no intake while the offset table is rebuilt
  busy_blocks_req: assert property (@(posedge clk) disable iff (!rst_n)
    table_busy |-> !req_ready)
    else $error("request accepted during table rebuild");

endmodule

bind tex_unit_top tex_unit_assert u_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .req_valid  (req_valid),
  .req_ready  (req_ready),
  .req        (req),
  .resp_valid (resp_valid),
  .resp_ready (resp_ready),
  .resp       (resp),
  .table_busy (table_busy)
);

`default_nettype wire

/* sim/tex_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "tex_config.svh"

module tex_unit_tb;

  localparam int          CLK_HALF  = 10;
  localparam int          DRIVE_DLY = 2;
  localparam int          MEM_DEPTH = 2 ** `TEX_MEM_AW;
  localparam logic [31:0] PATTERN   = 32'h5a000000;
  localparam logic [31:0] SEED      = 32'h9ceb505d;
  localparam string       STIM_FILE = "sim/tex_stimulus.txt";

  typedef struct packed {
    logic               is_cfg;
    tex_pkg::tex_cfg_t  cfg;
    tex_pkg::tex_req_t  req;
    tex_pkg::tex_resp_t exp;
  } step_t;

  logic                    clk;
  logic                    rst_n;
  tex_pkg::tex_cfg_t       cfg;
  logic                    cfg_load;
  logic                    mem_we;
  logic [`TEX_MEM_AW-1:0]  mem_waddr;
  logic [`TEX_TEXEL_W-1:0] mem_wdata;
  logic                    req_valid;
  logic                    req_ready;
  tex_pkg::tex_req_t       req;
  logic                    resp_valid;
  logic                    resp_ready;
  tex_pkg::tex_resp_t      resp;

  step_t              steps[$];
  string              step_names[$];
  tex_pkg::tex_resp_t exp_q[$];
  string              exp_name_q[$];
  int                 errors;
  int                 n_req;
  int                 n_resp;
  logic [31:0]        lcg_state;
  logic               load_done;

  tex_unit_top u_tex_unit_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .cfg_load   (cfg_load),
    .mem_we     (mem_we),
    .mem_waddr  (mem_waddr),
    .mem_wdata  (mem_wdata),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
  );

  always #CLK_HALF clk = ~clk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // sink stalls about 30% of the cycles
  always @(posedge clk) begin
    #DRIVE_DLY;
    resp_ready = ((next_random() >> 16) % 32'd100) < 32'd70;
  end

  task automatic read_stimulus;
    int                     fd;
    int                     code;
    string                  tag;
    string                  name;
    string                  rest;
    int                     w;
    int                     h;
    int                     lod;
    int                     wu;
    int                     wv;
    int                     ex;
    int                     ey;
    logic [31:0]            u;
    logic [31:0]            v;
    logic [`TEX_MEM_AW-1:0] ea;
    step_t                  s;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("could not open stimulus file %s", STIM_FILE);
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1)
        break;
      s = '0;
      if (tag == "#") begin
        code = $fgets(rest, fd);  // column description
      end else if (tag == "cfg") begin
        code = $fscanf(fd, "%d %d", w, h);
        s.is_cfg          = 1'b1;
        s.cfg.base_width  = `TEX_DIM_W'(w);
        s.cfg.base_height = `TEX_DIM_W'(h);
        steps.push_back(s);
        step_names.push_back("cfg");
      end else if (tag == "req") begin
        code = $fscanf(fd, "%s %h %h %d %d %d %d %d %d", name, u, v, lod, wu, wv, ex, ey, ea);
        if (code != 9) begin
          errors++;
          $display("malformed request line in stimulus file after %0d requests", n_req);
        end
        s.req.u      = u;
        s.req.v      = v;
        s.req.lod    = `TEX_LOD_W'(lod);
        s.req.wrap_u = tex_pkg::wrap_mode_e'(wu[1:0]);
        s.req.wrap_v = tex_pkg::wrap_mode_e'(wv[1:0]);
        s.exp.texel  = `TEX_TEXEL_W'(ea) ^ PATTERN;  // memory fill rule
        s.exp.tex_x  = `TEX_DIM_W'(ex);
        s.exp.tex_y  = `TEX_DIM_W'(ey);
        s.exp.lod    = `TEX_LOD_W'(lod);
        steps.push_back(s);
        step_names.push_back(name);
        n_req++;
      end else begin
        errors++;
        $display("unknown line type %s in stimulus file", tag);
      end
    end
    $fclose(fd);
  endtask

  task automatic load_memory;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      mem_we    = 1'b1;
      mem_waddr = `TEX_MEM_AW'(a);
      mem_wdata = `TEX_TEXEL_W'(a) ^ PATTERN;
      @(posedge clk);
      #DRIVE_DLY;
    end
    mem_we = 1'b0;
  endtask

  task automatic drain_pipeline;
    req_valid = 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk);
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic load_config(input tex_pkg::tex_cfg_t c);
    cfg      = c;
    cfg_load = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    cfg_load = 1'b0;
    // table rebuild takes one level per cycle
    repeat (`TEX_LEVELS) begin
      @(negedge clk);
      if (req_ready) begin
        errors++;
        $display("req_ready high while the level table was rebuilt");
      end
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  task automatic send_request(input step_t s, input string name);
    logic taken;
    exp_q.push_back(s.exp);
    exp_name_q.push_back(name);
    req       = s.req;
    req_valid = 1'b1;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = req_ready;  // transfer on the coming edge
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  task automatic check_response(input tex_pkg::tex_resp_t got);
    tex_pkg::tex_resp_t want;
    string              name;
    n_resp++;
    if (exp_q.size() == 0) begin
      errors++;
      $display("response with no request outstanding, texel %h", got.texel);
      return;
    end
    want = exp_q.pop_front();
    name = exp_name_q.pop_front();
    if (got.texel !== want.texel) begin
      errors++;
      $display("Mismatch %s texel: expected %h, actual %h", name, want.texel, got.texel);
    end
    if (got.tex_x !== want.tex_x) begin
      errors++;
      $display("Mismatch %s tex_x: expected %0d, actual %0d", name, want.tex_x, got.tex_x);
    end
    if (got.tex_y !== want.tex_y) begin
      errors++;
      $display("Mismatch %s tex_y: expected %0d, actual %0d", name, want.tex_y, got.tex_y);
    end
    if (got.lod !== want.lod) begin
      errors++;
      $display("Mismatch %s lod: expected %0d, actual %0d", name, want.lod, got.lod);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      if (resp_valid) begin
        errors++;
        $display("resp_valid high during reset");
      end
    end else if (resp_valid && resp_ready) begin
      check_response(resp);
    end
  end

  // budget counts from the end of the memory load
  initial begin
    wait (load_done);
    repeat (40 * n_req + 200) @(posedge clk);
    errors++;
    $display("timeout with %0d responses still outstanding", exp_q.size());
    $display("errors: %0d, requests: %0d, responses: %0d", errors, n_req, n_resp);
    $display("sim failed");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    cfg        = '0;
    cfg_load   = 1'b0;
    mem_we     = 1'b0;
    mem_waddr  = '0;
    mem_wdata  = '0;
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b0;
    errors     = 0;
    n_req      = 0;
    n_resp     = 0;
    lcg_state  = SEED;
    load_done  = 1'b0;
    read_stimulus();
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    load_memory();
    load_done = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      if (steps[i].is_cfg) begin
        drain_pipeline();  // nothing in flight across a table rebuild
        load_config(steps[i].cfg);
      end else begin
        send_request(steps[i], step_names[i]);
      end
    end
    drain_pipeline();
    repeat (4) @(posedge clk);  // catch stray responses
    if (n_resp != n_req) begin
      errors++;
      $display("response count differs from request count");
    end
    $display("errors: %0d, requests: %0d, responses: %0d", errors, n_req, n_resp);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/tex_pkg.sv
hdl/tex_addr_gen.sv
hdl/mip_offset_calc.sv
hdl/texel_mem.sv
hdl/tex_fetch.sv
hdl/tex_unit_top.sv
sim/tex_unit_assert.sv
sim/tex_unit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the texture unit testbench with Verilator, log goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tex_unit_tb -f all.f -o tex_unit_sim \
  && ./obj_dir/tex_unit_sim > sim.log 2>&1 \
  || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

/* sim/tex_stimulus.txt */
# cfg base_width base_height | wrap codes 0 clamp, 1 repeat, 2 mirror, 3 clamp
# req name u(hex Q16.16) v(hex Q16.16) lod wrap_u wrap_v exp_x exp_y exp_addr
cfg 64 32
req clamp_mid      00008000 00004000 0 0 0 32  8  544
req clamp_hi       00010000 00028000 0 0 0 63 31 2047
req clamp_code3    00018000 0000c000 0 3 3 63 24 1599
req repeat_xy      00018000 00026000 0 1 1 32 12  800
req repeat_u_clamp 00030400 00014000 0 1 0  1 31 1985
req mirror_first   00004000 00008000 0 2 2 16 16 1040
req mirror_second  00014000 00018000 0 2 2 47 15 1007
req mirror_u_rep_v 0001fc00 00018000 0 2 1  0 16 1024
req lod0           00008000 00008000 0 0 0 32 16 1056
req lod1           0000c000 00004000 1 0 0 24  4 2200
req lod2           00008000 0000c000 2 0 0  8  6 2664
req lod3           0000e000 00008000 3 0 0  7  2 2711
req lod4           00008000 00008000 4 0 0  2  1 2726
req lod5           0000c000 0000c000 5 0 0  1  0 2729
req lod6           0000c000 00008000 6 0 0  0  0 2730
req lod5_mirror    00018000 00018000 5 2 2  0  0 2728
req lod1_repeat    00028000 00013000 1 1 1 16  3 2160
cfg 16 64
req reconf_lod0    00008000 0000c000 0 0 0  8 48  776
req reconf_lod1    0000e000 00008000 1 0 0  7 16 1159
req reconf_lod3    00018000 00028000 3 1 1  1  4 1353
req reconf_lod4    00008000 00018000 4 2 2  0  1 1361
req reconf_lod6    00008000 00008000 6 0 0  0  0 1366
